// ==== project.f ====
source/ppu_pkg.sv
source/ppu_config_reg.sv
source/test_pattern_insert.sv
source/rgb_ypbpr_matrix.sv
source/video_out_format.sv
source/ppu_out_top.sv
verif/tb_clock_gen.sv
verif/tb_ppu_checker.sv
verif/tb_ppu_out.sv

// ==== source/ppu_config_reg.sv ====
//--------------------------------------------------------------------------
// Configuration register
// Samples the raw configuration word and the mode flags, applies the
// line multiplier rules and the filter selection, and reports a status
// byte for the controller
//--------------------------------------------------------------------------

module ppu_config_reg (
  input  logic                 VCLK_Tx,
  input  logic                 nVRST_Tx,
  input  ppu_pkg::config_set_t config_set_i,
  input  logic                 palmode_i,
  input  logic                 n64_480i_i,
  input  logic                 use_vpll_i,
  output ppu_pkg::ppu_cfg_t    cfg_o,
  output ppu_pkg::linemult_t   vclk_tx_select_o,
  output logic [7:0]           ppu_state_o
);

  import ppu_pkg::*;

  ppu_cfg_t   cfg_d;
  ppu_cfg_t   cfg_q;
  logic [7:0] state_d;
  logic [7:0] state_q;

  //------------------------------------------------------------------------
  // Decode
  //------------------------------------------------------------------------

  always_comb begin
    cfg_d                = '0;
    cfg_d.testpat        = config_set_i.show_testpat;
    cfg_d.exchange_rb    = config_set_i.exchange_rb;
    cfg_d.ypbpr_en       = config_set_i.ypbpr_en;
    // Sync on green needed for YPbPr and RGsB
    cfg_d.csync_on_green = config_set_i.ypbpr_en | config_set_i.rgsb_en;

    // 480i only knows x2
    if (n64_480i_i) begin
      cfg_d.linemult = config_set_i.v480i_linex2 ? lm_x2 : lm_off;
    // No x3 in PAL or without the video PLL
    end else if (palmode_i || !use_vpll_i) begin
      cfg_d.linemult = (^config_set_i.v240p_linemult) ? lm_x2 : lm_off;
    end else begin
      cfg_d.linemult = config_set_i.v240p_linemult;
    end

    // Test pattern runs at native line rate
    if (config_set_i.show_testpat) begin
      cfg_d.linemult = lm_off;
    end

    // Auto filter follows the output line rate
    if (config_set_i.filter_set == 3'd0) begin
      cfg_d.filter = cfg_d.linemult;
    end else begin
      cfg_d.filter = config_set_i.filter_set[1:0] - 2'd1;
    end
  end

  // Status byte, top bit first
  assign state_d = {palmode_i,
                    n64_480i_i,
                    cfg_d.linemult,
                    config_set_i.ypbpr_en,
                    config_set_i.rgsb_en,
                    cfg_d.filter};

  //------------------------------------------------------------------------
  // Registers
  //------------------------------------------------------------------------

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      cfg_q   <= '0;
      state_q <= '0;
    end else begin
      cfg_q   <= cfg_d;
      state_q <= state_d;
    end
  end

  assign cfg_o            = cfg_q;
  assign vclk_tx_select_o = cfg_q.linemult;
  assign ppu_state_o      = state_q;

  // PAL never leaves this block with x3 selected
  a_no_x3_in_pal: assert property (
    @(posedge VCLK_Tx) disable iff (!nVRST_Tx)
    palmode_i |=> (cfg_q.linemult != lm_x3)
  ) else $error("line multiplier x3 decoded in PAL mode");

endmodule

// ==== source/ppu_out_top.sv ====
//--------------------------------------------------------------------------
// Post-processor output stage top level
// Configuration register, test pattern, colour matrix and output
// formatter, all in the transmit clock domain
//--------------------------------------------------------------------------

module ppu_out_top #(
  parameter int bar_shift = 3
) (
  input  logic                 VCLK_Tx,
  input  logic                 nVRST_Tx,
  input  logic                 vdata_valid_i,
  input  ppu_pkg::pixel_t      vdata_i,
  input  ppu_pkg::config_set_t config_set_i,
  input  logic                 palmode_i,
  input  logic                 n64_480i_i,
  input  logic                 use_vpll_i,
  input  logic                 use_vga_hvsync_i,
  output logic [7:0]           ppu_state_o,
  output ppu_pkg::linemult_t   vclk_tx_select_o,
  output logic [23:0]          vd_o,
  output logic [1:0]           ncsync_o,
  output logic                 nvsync_or_f2_o,
  output logic                 nhsync_or_f1_o,
  output logic                 vdata_valid_o
);

  import ppu_pkg::*;

  ppu_cfg_t cfg;
  logic     tp_valid;
  pixel_t   tp_pixel;
  logic     mx_valid;
  pixel_t   mx_pixel;

  // Decoded settings, one cycle behind the raw word
  ppu_config_reg config_reg_u (
    .VCLK_Tx         (VCLK_Tx),
    .nVRST_Tx        (nVRST_Tx),
    .config_set_i    (config_set_i),
    .palmode_i       (palmode_i),
    .n64_480i_i      (n64_480i_i),
    .use_vpll_i      (use_vpll_i),
    .cfg_o           (cfg),
    .vclk_tx_select_o(vclk_tx_select_o),
    .ppu_state_o     (ppu_state_o)
  );

  // Pixel path, 1 + 3 + 1 cycles
  test_pattern_insert #(
    .bar_shift(bar_shift)
  ) testpat_u (
    .VCLK_Tx      (VCLK_Tx),
    .nVRST_Tx     (nVRST_Tx),
    .cfg_i        (cfg),
    .vdata_valid_i(vdata_valid_i),
    .vdata_i      (vdata_i),
    .vdata_valid_o(tp_valid),
    .vdata_o      (tp_pixel)
  );

  rgb_ypbpr_matrix matrix_u (
    .VCLK_Tx      (VCLK_Tx),
    .nVRST_Tx     (nVRST_Tx),
    .cfg_i        (cfg),
    .vdata_valid_i(tp_valid),
    .vdata_i      (tp_pixel),
    .vdata_valid_o(mx_valid),
    .vdata_o      (mx_pixel)
  );

  video_out_format format_u (
    .VCLK_Tx         (VCLK_Tx),
    .nVRST_Tx        (nVRST_Tx),
    .cfg_i           (cfg),
    .vdata_valid_i   (mx_valid),
    .vdata_i         (mx_pixel),
    .use_vga_hvsync_i(use_vga_hvsync_i),
    .vd_o            (vd_o),
    .ncsync_o        (ncsync_o),
    .nvsync_or_f2_o  (nvsync_or_f2_o),
    .nhsync_or_f1_o  (nhsync_or_f1_o),
    .vdata_valid_o   (vdata_valid_o)
  );

endmodule

// ==== source/ppu_pkg.sv ====
//--------------------------------------------------------------------------
// Post-processor output stage common definitions
// Pixel and sync types, raw configuration word layout, decoded settings
// and the fixed point coefficients of the RGB to YPbPr matrix
//--------------------------------------------------------------------------

package ppu_pkg;

  // Basic vector types
  typedef logic [7:0] color_t;
  typedef logic [3:0] sync_t;
  typedef logic [1:0] linemult_t;
  typedef logic [1:0] filter_t;

  // Sync bit positions, all active low
  // Bit 2 carries nCLAMP and is only passed along
  localparam int sync_vs_bit = 3;
  localparam int sync_hs_bit = 1;
  localparam int sync_cs_bit = 0;

  // Line multiplier codes
  localparam linemult_t lm_off = 2'd0;
  localparam linemult_t lm_x2  = 2'd1;
  localparam linemult_t lm_x3  = 2'd2;

  // One pixel with its sync, 28 bits
  // Matrix on puts Pb in red, Y in green and Pr in blue
  typedef struct packed {
    sync_t  sync;
    color_t red;
    color_t green;
    color_t blue;
  } pixel_t;

  // Raw configuration word as delivered by the controller
  typedef struct packed {
    logic       show_testpat;
    logic       exchange_rb;
    logic [2:0] filter_set;      // 0 selects auto filter
    logic       ypbpr_en;
    logic       rgsb_en;
    linemult_t  v240p_linemult;
    logic       v480i_linex2;
  } config_set_t;

  // Decoded settings shared by the output blocks
  typedef struct packed {
    logic      testpat;
    logic      exchange_rb;
    logic      ypbpr_en;
    logic      csync_on_green;
    linemult_t linemult;
    filter_t   filter;
  } ppu_cfg_t;

  // Matrix arithmetic widths
  typedef logic signed [8:0]  coef_t;
  typedef logic signed [17:0] prod_t;
  typedef logic signed [19:0] sum_t;

  // Coefficients scaled by 256
  localparam coef_t coef_y_r  =  9'sd77;
  localparam coef_t coef_y_g  =  9'sd150;
  localparam coef_t coef_y_b  =  9'sd29;
  localparam coef_t coef_pb_r = -9'sd43;
  localparam coef_t coef_pb_g = -9'sd85;
  localparam coef_t coef_pb_b =  9'sd128;
  localparam coef_t coef_pr_r =  9'sd128;
  localparam coef_t coef_pr_g = -9'sd107;
  localparam coef_t coef_pr_b = -9'sd21;

endpackage

// ==== source/rgb_ypbpr_matrix.sv ====
//--------------------------------------------------------------------------
// RGB to YPbPr colour matrix
// Three pipeline stages: products, sums, then offset, scaling and clamp
// Bypass takes the same three cycles so latency never depends on mode
//--------------------------------------------------------------------------

module rgb_ypbpr_matrix (
  input  logic              VCLK_Tx,
  input  logic              nVRST_Tx,
  input  ppu_pkg::ppu_cfg_t cfg_i,
  input  logic              vdata_valid_i,
  input  ppu_pkg::pixel_t   vdata_i,
  output logic              vdata_valid_o,
  output ppu_pkg::pixel_t   vdata_o
);

  import ppu_pkg::*;

  // Rows Y, Pb, Pr and columns R, G, B
  localparam coef_t coef_tab [3][3] = '{
    '{coef_y_r,  coef_y_g,  coef_y_b},
    '{coef_pb_r, coef_pb_g, coef_pb_b},
    '{coef_pr_r, coef_pr_g, coef_pr_b}
  };

  // Colour difference outputs sit around mid scale
  localparam sum_t offset_tab [3] = '{20'sd0, 20'sd128, 20'sd128};

  logic [1:0] valid_q;
  color_t     rgb [3];
  prod_t      prod_q [3][3];
  sum_t       sum_q [3];
  sum_t       scaled [3];
  pixel_t     pix_d1;
  pixel_t     pix_d2;

  // Limit a scaled result to the 8 bit range
  function automatic color_t clamp_color(input sum_t val);
    if (val < 0) begin
      return 8'h00;
    end
    if (val > 255) begin
      return 8'hff;
    end
    return color_t'(val);
  endfunction

  always_comb begin
    rgb[0] = vdata_i.red;
    rgb[1] = vdata_i.green;
    rgb[2] = vdata_i.blue;
  end

  //------------------------------------------------------------------------
  // Stage 1 and 2
  //------------------------------------------------------------------------

  // Nine products, colour taken as unsigned
  always_ff @(posedge VCLK_Tx) begin
    for (int o = 0; o < 3; o++) begin
      for (int c = 0; c < 3; c++) begin
        prod_q[o][c] <= $signed({1'b0, rgb[c]}) * coef_tab[o][c];
      end
    end
    pix_d1 <= vdata_i;
  end

  // One sum per output component
  always_ff @(posedge VCLK_Tx) begin
    for (int o = 0; o < 3; o++) begin
      sum_q[o] <= prod_q[o][0] + prod_q[o][1] + prod_q[o][2];
    end
    pix_d2 <= pix_d1;
  end

  //------------------------------------------------------------------------
  // Stage 3
  //------------------------------------------------------------------------

  // Divide by 256 with sign, then offset
  always_comb begin
    for (int o = 0; o < 3; o++) begin
      scaled[o] = (sum_q[o] >>> 8) + offset_tab[o];
    end
  end

  always_ff @(posedge VCLK_Tx) begin
    if (cfg_i.ypbpr_en) begin
      vdata_o.sync  <= pix_d2.sync;
      // Pb first, Y in the middle, Pr last
      vdata_o.red   <= clamp_color(scaled[1]);
      vdata_o.green <= clamp_color(scaled[0]);
      vdata_o.blue  <= clamp_color(scaled[2]);
    end else begin
      vdata_o <= pix_d2;
    end
  end

  // Valid strobe follows the data through all three stages
  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      valid_q       <= '0;
      vdata_valid_o <= 1'b0;
    end else begin
      valid_q       <= {valid_q[0], vdata_valid_i};
      vdata_valid_o <= valid_q[1];
    end
  end

  a_three_cycle_latency: assert property (
    @(posedge VCLK_Tx) disable iff (!nVRST_Tx)
    vdata_valid_o == $past(vdata_valid_i, 3)
  ) else $error("matrix valid strobe out of step with its input");

endmodule

// ==== source/test_pattern_insert.sv ====
//--------------------------------------------------------------------------
// Test pattern inserter
// Counts pixels from the falling edge of nHSYNC and replaces the colour
// of each pixel with vertical colour bars while the pattern is enabled
//--------------------------------------------------------------------------

module test_pattern_insert #(
  parameter int bar_shift = 3
) (
  input  logic              VCLK_Tx,
  input  logic              nVRST_Tx,
  input  ppu_pkg::ppu_cfg_t cfg_i,
  input  logic              vdata_valid_i,
  input  ppu_pkg::pixel_t   vdata_i,
  output logic              vdata_valid_o,
  output ppu_pkg::pixel_t   vdata_o
);

  import ppu_pkg::*;

  // Counter wide enough for the three bar index bits
  localparam int cnt_w = bar_shift + 3;

  logic             nhsync_prev;
  logic             half_q;
  logic [cnt_w-1:0] pix_cnt_q;
  logic             hs_fall;
  logic             half_cur;
  logic [cnt_w-1:0] pix_cnt_cur;
  logic [2:0]       bar_idx;
  pixel_t           bar_pixel;

  // Line start seen against the previous valid pixel
  assign hs_fall = nhsync_prev & ~vdata_i.sync[sync_hs_bit];

  // Pixel at the edge is pixel 0 of the line
  assign half_cur    = hs_fall ? 1'b0 : half_q;
  assign pix_cnt_cur = hs_fall ? '0 : pix_cnt_q;
  assign bar_idx     = pix_cnt_cur[bar_shift+2:bar_shift];

  // Bars in binary order, red on the top index bit
  always_comb begin
    bar_pixel.sync  = vdata_i.sync;
    bar_pixel.red   = bar_idx[2] ? 8'hff : 8'h00;
    bar_pixel.green = bar_idx[1] ? 8'hff : 8'h00;
    bar_pixel.blue  = bar_idx[0] ? 8'hff : 8'h00;
  end

  //------------------------------------------------------------------------
  // Horizontal position
  //------------------------------------------------------------------------

  // Counter advances on every second valid pixel
  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      nhsync_prev <= 1'b1;
      half_q      <= 1'b0;
      pix_cnt_q   <= '0;
    end else if (vdata_valid_i) begin
      nhsync_prev <= vdata_i.sync[sync_hs_bit];
      half_q      <= ~half_cur;
      pix_cnt_q   <= pix_cnt_cur + cnt_w'(half_cur);
    end
  end

  //------------------------------------------------------------------------
  // Output select
  //------------------------------------------------------------------------

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      vdata_valid_o <= 1'b0;
    end else begin
      vdata_valid_o <= vdata_valid_i;
    end
  end

  // Pixel held over gaps
  always_ff @(posedge VCLK_Tx) begin
    if (vdata_valid_i) begin
      vdata_o <= cfg_i.testpat ? bar_pixel : vdata_i;
    end
  end

endmodule

// ==== source/video_out_format.sv ====
//--------------------------------------------------------------------------
// Output formatter
// Final registers in front of the DAC: colour with optional red/blue
// exchange, both composite sync pins and the shared VGA sync or filter
// add-on select pins
//--------------------------------------------------------------------------

module video_out_format (
  input  logic              VCLK_Tx,
  input  logic              nVRST_Tx,
  input  ppu_pkg::ppu_cfg_t cfg_i,
  input  logic              vdata_valid_i,
  input  ppu_pkg::pixel_t   vdata_i,
  input  logic              use_vga_hvsync_i,
  output logic [23:0]       vd_o,
  output logic [1:0]        ncsync_o,
  output logic              nvsync_or_f2_o,
  output logic              nhsync_or_f1_o,
  output logic              vdata_valid_o
);

  import ppu_pkg::*;

  logic [23:0] vd_next;

  // Swap first and third component on request
  assign vd_next = cfg_i.exchange_rb ? {vdata_i.blue, vdata_i.green, vdata_i.red}
                                     : {vdata_i.red, vdata_i.green, vdata_i.blue};

  //------------------------------------------------------------------------
  // Colour and composite sync
  //------------------------------------------------------------------------

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      vd_o          <= '0;
      ncsync_o      <= '0;
      vdata_valid_o <= 1'b0;
    end else begin
      vdata_valid_o <= vdata_valid_i;
      if (vdata_valid_i) begin
        vd_o        <= vd_next;
        // Sync pin for the DAC sync input
        ncsync_o[1] <= vdata_i.sync[sync_cs_bit];
        // Held low unless sync rides on green
        ncsync_o[0] <= cfg_i.csync_on_green & vdata_i.sync[sync_cs_bit];
      end
    end
  end

  //------------------------------------------------------------------------
  // VGA sync or filter select
  //------------------------------------------------------------------------

  // Filter codes 0 to 3 select SD, ED, HD and FHD
  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      nvsync_or_f2_o <= 1'b0;
      nhsync_or_f1_o <= 1'b0;
    end else if (use_vga_hvsync_i) begin
      nvsync_or_f2_o <= vdata_i.sync[sync_vs_bit];
      nhsync_or_f1_o <= vdata_i.sync[sync_hs_bit];
    end else begin
      nvsync_or_f2_o <= cfg_i.filter[1];
      nhsync_or_f1_o <= cfg_i.filter[0];
    end
  end

endmodule

// ==== verif/tb_clock_gen.sv ====
//--------------------------------------------------------------------------
// Testbench clock and reset
// 20 unit clock period, reset held low for the first 8 cycles
//--------------------------------------------------------------------------

module tb_clock_gen (
  output logic vclk_o,
  output logic nvrst_o
);

  initial begin
    vclk_o  = 1'b0;
    nvrst_o = 1'b0;
    forever #10 vclk_o = ~vclk_o;
  end

  // Release away from the rising edge
  initial begin
    repeat (8) @(posedge vclk_o);
    @(negedge vclk_o);
    nvrst_o = 1'b1;
  end

endmodule

// ==== verif/tb_ppu_checker.sv ====
//--------------------------------------------------------------------------
// Output checker
// Holds the expected output words in order and compares each valid DUT
// output with the oldest one, including the pixel latency
//--------------------------------------------------------------------------

module tb_ppu_checker (
  input  logic        VCLK_Tx,
  input  logic [7:0]  ppu_state_i,
  input  logic [1:0]  vclk_tx_select_i,
  input  logic [23:0] vd_i,
  input  logic [1:0]  ncsync_i,
  input  logic        nvsync_or_f2_i,
  input  logic        nhsync_or_f1_i,
  input  logic        vdata_valid_i
);

  // Fixed pipeline depth of the DUT
  localparam int latency = 5;

  // Word layout: sync pins, ncsync, then the three components
  logic [27:0] exp_q [$];
  int          stamp_q [$];
  logic [27:0] exp_word;
  logic [27:0] act_word;
  int          stamp;
  int          cycle_cnt = 0;
  string       test_name = "reset";
  int          test_errors = 0;
  int          pixels_seen = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          total_errors = 0;

  always @(posedge VCLK_Tx) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
    pixels_seen = 0;
  endtask

  // Called by the driver when a valid pixel goes in
  task automatic expect_pixel(input logic [27:0] word);
    exp_q.push_back(word);
    stamp_q.push_back(cycle_cnt);
  endtask

  function automatic int outstanding();
    return exp_q.size();
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("CHECK FAILED %s %s expected %h actual %h", test_name, what, exp, act);
    test_errors++;
    total_errors++;
  endtask

  task automatic report_problem(input string msg);
    $display("ERROR in %s: %s", test_name, msg);
    test_errors++;
    total_errors++;
  endtask

  task automatic drop_pending();
    exp_q.delete();
    stamp_q.delete();
  endtask

  // Status byte and clock select against the decoded rules
  task automatic check_status(input logic [7:0] exp_state, input logic [1:0] exp_sel);
    if (ppu_state_i !== exp_state) begin
      report_mismatch("ppu_state", exp_state, ppu_state_i);
    end
    if (vclk_tx_select_i !== exp_sel) begin
      report_mismatch("vclk_tx_select", exp_sel, vclk_tx_select_i);
    end
  endtask

  // Every output low straight after reset
  task automatic check_reset();
    check_status(8'h00, 2'b00);
    if (vd_i !== 24'h0) begin
      report_mismatch("vd", 24'h0, vd_i);
    end
    if ({ncsync_i, nvsync_or_f2_i, nhsync_or_f1_i, vdata_valid_i} !== 5'b0) begin
      report_mismatch("sync pins and valid", 5'b0,
                      {ncsync_i, nvsync_or_f2_i, nhsync_or_f1_i, vdata_valid_i});
    end
  endtask

  //------------------------------------------------------------------------
  // Output pixel compare
  //------------------------------------------------------------------------

  always @(negedge VCLK_Tx) begin
    if (vdata_valid_i === 1'b1) begin
      if (exp_q.size() == 0) begin
        report_problem("output valid without any pixel pending");
      end else begin
        exp_word = exp_q.pop_front();
        stamp    = stamp_q.pop_front();
        act_word = {nvsync_or_f2_i, nhsync_or_f1_i, ncsync_i, vd_i};
        pixels_seen++;
        if (cycle_cnt - stamp != latency) begin
          report_mismatch("latency", latency, cycle_cnt - stamp);
        end
        if (act_word !== exp_word) begin
          report_mismatch("output word", exp_word, act_word);
        end
      end
    end
  end

  task automatic end_test();
    tests_run++;
    if (test_errors != 0) begin
      tests_failed++;
    end
    $display("test %-18s %3d pixels checked, %0d errors", test_name, pixels_seen,
             test_errors);
  endtask

  task automatic print_summary();
    $display("%0d tests run, %0d with errors, %0d errors in total", tests_run,
             tests_failed, total_errors);
  endtask

endmodule

// ==== verif/tb_ppu_out.sv ====
//--------------------------------------------------------------------------
// Testbench for the post-processor output stage
// Applies a table of configurations and pixel streams on the falling
// clock edge and hands the expected output words to the checker
//--------------------------------------------------------------------------

module tb_ppu_out;

  import ppu_pkg::*;

  localparam int bar_shift = 3;
  localparam int max_tests = 16;
  localparam int wait_limit = 100;

  // Pixel sources
  localparam logic [1:0] src_lcg     = 2'd0;
  localparam logic [1:0] src_gaps    = 2'd1;
  localparam logic [1:0] src_primary = 2'd2;
  localparam logic [1:0] src_line    = 2'd3;

  // One table row without its name
  typedef struct packed {
    config_set_t cfg;
    logic        palmode;
    logic        n64_480i;
    logic        use_vpll;
    logic        use_vga;
    logic [1:0]  src;
    logic [7:0]  count;
  } test_vec_t;

  logic        VCLK_Tx;
  logic        nVRST_Tx;
  logic        vdata_valid;
  pixel_t      vdata;
  config_set_t config_set;
  logic        palmode;
  logic        n64_480i;
  logic        use_vpll;
  logic        use_vga_hvsync;
  logic [7:0]  ppu_state;
  linemult_t   vclk_tx_select;
  logic [23:0] vd;
  logic [1:0]  ncsync;
  logic        nvsync_or_f2;
  logic        nhsync_or_f1;
  logic        vdata_valid_out;

  test_vec_t   vec_tab [max_tests];
  string       name_tab [max_tests];
  int          num_tests = 0;
  logic [31:0] lcg_state = 32'h7887_faf0;
  // Line position model for the colour bars
  logic        model_prev_hs = 1'b1;
  int          model_line_pos = 0;
  int          waited;

  tb_clock_gen clock_u (
    .vclk_o (VCLK_Tx),
    .nvrst_o(nVRST_Tx)
  );

  ppu_out_top #(
    .bar_shift(bar_shift)
  ) UUT (
    .VCLK_Tx         (VCLK_Tx),
    .nVRST_Tx        (nVRST_Tx),
    .vdata_valid_i   (vdata_valid),
    .vdata_i         (vdata),
    .config_set_i    (config_set),
    .palmode_i       (palmode),
    .n64_480i_i      (n64_480i),
    .use_vpll_i      (use_vpll),
    .use_vga_hvsync_i(use_vga_hvsync),
    .ppu_state_o     (ppu_state),
    .vclk_tx_select_o(vclk_tx_select),
    .vd_o            (vd),
    .ncsync_o        (ncsync),
    .nvsync_or_f2_o  (nvsync_or_f2),
    .nhsync_or_f1_o  (nhsync_or_f1),
    .vdata_valid_o   (vdata_valid_out)
  );

  tb_ppu_checker checker_u (
    .VCLK_Tx         (VCLK_Tx),
    .ppu_state_i     (ppu_state),
    .vclk_tx_select_i(vclk_tx_select),
    .vd_i            (vd),
    .ncsync_i        (ncsync),
    .nvsync_or_f2_i  (nvsync_or_f2),
    .nhsync_or_f1_i  (nhsync_or_f1),
    .vdata_valid_i   (vdata_valid_out)
  );

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  //------------------------------------------------------------------------
  // Reference rules
  //------------------------------------------------------------------------

  // x3 demoted in PAL or without PLL, 480i knows x2 only
  function automatic linemult_t decode_linemult(input test_vec_t v);
    if (v.cfg.show_testpat) begin
      return 2'd0;
    end
    if (v.n64_480i) begin
      return {1'b0, v.cfg.v480i_linex2};
    end
    if (v.palmode || !v.use_vpll) begin
      return (v.cfg.v240p_linemult inside {2'd1, 2'd2}) ? 2'd1 : 2'd0;
    end
    return v.cfg.v240p_linemult;
  endfunction

  // Auto follows the line multiplier, manual codes start at 1
  function automatic filter_t decode_filter(input test_vec_t v);
    if (v.cfg.filter_set == 3'd0) begin
      return decode_linemult(v);
    end
    return v.cfg.filter_set[1:0] - 2'd1;
  endfunction

  function automatic logic [7:0] status_byte(input test_vec_t v);
    return {v.palmode, v.n64_480i, decode_linemult(v), v.cfg.ypbpr_en, v.cfg.rgsb_en,
            decode_filter(v)};
  endfunction

  // Weights scaled by 256, floor division, clamped
  function automatic color_t matrix_component(input int kr, input int kg, input int kb,
                                              input int offs, input pixel_t p);
    int acc;
    acc = kr * int'(p.red) + kg * int'(p.green) + kb * int'(p.blue);
    acc = offs + (acc >>> 8);
    if (acc < 0) begin
      return 8'h00;
    end
    if (acc > 255) begin
      return 8'hff;
    end
    return acc[7:0];
  endfunction

  function automatic logic [27:0] expected_output(input test_vec_t v, input pixel_t p,
                                                  input int bar);
    pixel_t     q;
    color_t     c1;
    color_t     c2;
    color_t     c3;
    color_t     tmp;
    logic       cs;
    logic [1:0] pins;
    q = p;
    if (v.cfg.show_testpat) begin
      q.red   = bar[2] ? 8'hff : 8'h00;
      q.green = bar[1] ? 8'hff : 8'h00;
      q.blue  = bar[0] ? 8'hff : 8'h00;
    end
    c1 = q.red;
    c2 = q.green;
    c3 = q.blue;
    // Pb, Y, Pr in component order
    if (v.cfg.ypbpr_en) begin
      c1 = matrix_component(-43, -85, 128, 128, q);
      c2 = matrix_component(77, 150, 29, 0, q);
      c3 = matrix_component(128, -107, -21, 128, q);
    end
    if (v.cfg.exchange_rb) begin
      tmp = c1;
      c1  = c3;
      c3  = tmp;
    end
    cs   = p.sync[0];
    pins = v.use_vga ? {p.sync[3], p.sync[1]} : decode_filter(v);
    return {pins, cs, cs & (v.cfg.ypbpr_en | v.cfg.rgsb_en), c1, c2, c3};
  endfunction

  //------------------------------------------------------------------------
  // Stimulus
  //------------------------------------------------------------------------

  function automatic pixel_t make_pixel(input test_vec_t v, input int i);
    pixel_t p;
    logic   hs;
    p = pixel_t'(next_random());
    if (v.src == src_primary) begin
      p.red   = i[2] ? 8'hff : 8'h00;
      p.green = i[1] ? 8'hff : 8'h00;
      p.blue  = i[0] ? 8'hff : 8'h00;
    end else if (v.src == src_line) begin
      // Short sync pulse after the first pixel
      hs     = !(i >= 1 && i < 9);
      p.sync = {1'b1, 1'b1, hs, hs};
    end
    return p;
  endfunction

  task automatic add_test(input string name, input logic tp, input logic xrb,
                          input logic [2:0] fset, input logic ypbpr, input logic rgsb,
                          input logic [1:0] lm, input logic lx2, input logic pal,
                          input logic i480, input logic vpll, input logic vga,
                          input logic [1:0] src, input int count);
    name_tab[num_tests] = name;
    vec_tab[num_tests]  = {tp, xrb, fset, ypbpr, rgsb, lm, lx2, pal, i480, vpll, vga,
                           src, 8'(count)};
    num_tests++;
  endtask

  task automatic run_test(input int idx);
    test_vec_t   v;
    pixel_t      p;
    logic [31:0] r;
    logic        valid;
    int          bar;
    int          wait_cnt;
    v = vec_tab[idx];
    @(negedge VCLK_Tx);
    vdata_valid    = 1'b0;
    config_set     = v.cfg;
    palmode        = v.palmode;
    n64_480i       = v.n64_480i;
    use_vpll       = v.use_vpll;
    use_vga_hvsync = v.use_vga;
    // Settings are registered once
    repeat (2) @(negedge VCLK_Tx);
    checker_u.start_test(name_tab[idx]);
    checker_u.check_status(status_byte(v), decode_linemult(v));
    for (int i = 0; i < v.count; i++) begin
      r     = next_random();
      valid = (v.src != src_gaps) || (r[31:30] != 2'b00);
      p     = make_pixel(v, i);
      vdata       = p;
      vdata_valid = valid;
      if (valid) begin
        if (model_prev_hs && !p.sync[1]) begin
          model_line_pos = 0;
        end
        bar = ((model_line_pos / 2) >> bar_shift) & 7;
        model_line_pos++;
        model_prev_hs = p.sync[1];
        checker_u.expect_pixel(expected_output(v, p, bar));
      end
      @(negedge VCLK_Tx);
    end
    vdata_valid = 1'b0;
    wait_cnt = 0;
    while (checker_u.outstanding() != 0 && wait_cnt < wait_limit) begin
      @(posedge VCLK_Tx);
      wait_cnt++;
    end
    if (checker_u.outstanding() != 0) begin
      checker_u.report_problem("timed out waiting for output pixels");
      checker_u.drop_pending();
    end
    checker_u.end_test();
  endtask

  initial begin
    vdata_valid    = 1'b0;
    vdata          = '0;
    config_set     = '0;
    palmode        = 1'b0;
    n64_480i       = 1'b0;
    use_vpll       = 1'b0;
    use_vga_hvsync = 1'b0;

    // name, tp, xrb, fset, ypbpr, rgsb, lm240, lx2, pal, 480i, vpll, vga, src, count
    add_test("passthrough_lcg", 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, src_lcg, 24);
    add_test("passthrough_gaps", 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, src_gaps, 40);
    add_test("exchange_rb", 0, 1, 0, 0, 0, 0, 0, 0, 0, 1, 0, src_lcg, 16);
    add_test("exchange_rgsb", 0, 1, 0, 0, 1, 0, 0, 0, 0, 1, 0, src_lcg, 16);
    add_test("ypbpr_lcg", 0, 0, 0, 1, 0, 0, 0, 0, 0, 1, 0, src_gaps, 32);
    add_test("ypbpr_primaries", 0, 0, 0, 1, 0, 0, 0, 0, 0, 1, 0, src_primary, 16);
    add_test("testpat_bars", 1, 0, 0, 0, 0, 2, 0, 0, 0, 1, 0, src_line, 140);
    add_test("lm_x3_ntsc", 0, 0, 0, 0, 0, 2, 0, 0, 0, 1, 0, src_lcg, 8);
    add_test("lm_x3_pal", 0, 0, 0, 0, 0, 2, 0, 1, 0, 1, 0, src_lcg, 8);
    add_test("lm_x3_no_pll", 0, 0, 0, 0, 0, 2, 0, 0, 0, 0, 0, src_lcg, 8);
    add_test("lm_480i_x2", 0, 0, 0, 0, 0, 2, 1, 0, 1, 1, 0, src_lcg, 8);
    add_test("filter_manual", 0, 0, 3, 0, 0, 1, 0, 0, 0, 1, 0, src_lcg, 8);
    add_test("filter_manual_wrap", 0, 0, 4, 0, 0, 0, 0, 0, 0, 1, 0, src_lcg, 8);
    add_test("vga_hvsync", 0, 0, 2, 1, 0, 1, 0, 0, 0, 1, 1, src_gaps, 32);

    // Wait for reset release
    waited = 0;
    while (nVRST_Tx !== 1'b1 && waited < 50) begin
      @(posedge VCLK_Tx);
      waited++;
    end
    @(negedge VCLK_Tx);
    checker_u.start_test("reset_values");
    if (nVRST_Tx !== 1'b1) begin
      checker_u.report_problem("reset was never released");
    end
    checker_u.check_reset();
    checker_u.end_test();

    for (int t = 0; t < num_tests; t++) begin
      run_test(t);
    end

    checker_u.print_summary();
    if (checker_u.total_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule
